/* hdl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // default geometry: 16 sets, 4 words per line
    localparam int INDEX_W        = 4;
    localparam int WORD_OFF_W     = 2;
    localparam int ADDR_W         = 32;
    localparam int WORDS_PER_LINE = 1 << WORD_OFF_W;
    localparam int LINE_W         = WORDS_PER_LINE * 32;
    localparam int TAG_W          = ADDR_W - INDEX_W - WORD_OFF_W - 2;

    typedef logic [ADDR_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [LINE_W/8-1:0] byte_en_t; // one bit per byte of a line

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        WAIT_WRITE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        WB_INIT,
        WB_WRITE,
        WB_FINISH
    } wb_state_e;

endpackage

`default_nettype wire

/* hdl/dcache_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// controller <-> tag/data arrays
interface way_port_if #(
    parameter int INDEX_WIDTH = dcache_pkg::INDEX_W
);
    logic [INDEX_WIDTH-1:0]      rd_index;
    logic [INDEX_WIDTH-1:0]      wr_index;
    dcache_pkg::tag_t            tag_in;     // compare and write tag
    logic [1:0]                  line_we;    // full line write per way
    dcache_pkg::byte_en_t [1:0]  byte_we;    // store bytes per way
    logic [1:0]                  tag_we;
    logic                        lru_we;
    logic                        lru_way;
    logic [1:0]                  dirty_we;
    logic                        dirty_val;
    dcache_pkg::line_t           wr_line;
    dcache_pkg::line_t [1:0]     rd_line;
    logic                        hit;
    logic                        hit_way;
    logic                        victim_way;
    logic                        victim_dirty;
    dcache_pkg::tag_t            victim_tag;
    dcache_pkg::line_t           victim_line;

    modport ctrl (
        output rd_index, wr_index, tag_in, line_we, byte_we, tag_we,
        output lru_we, lru_way, dirty_we, dirty_val, wr_line,
        input  rd_line, hit, hit_way, victim_way, victim_dirty, victim_tag, victim_line
    );

    modport store (
        input  rd_index, wr_index, tag_in, line_we, byte_we, tag_we,
        input  lru_we, lru_way, dirty_we, dirty_val, wr_line,
        output rd_line, hit, hit_way, victim_way, victim_dirty, victim_tag, victim_line
    );
endinterface

// controller <-> write-back unit
interface wb_port_if;
    logic              start;       // one cycle
    logic              clear;       // level, releases WB_FINISH
    dcache_pkg::word_t victim_addr;
    dcache_pkg::line_t victim_line;
    logic              need_write;
    logic              done;

    modport ctrl (output start, clear, victim_addr, victim_line, need_write, input done);
    modport wb (input start, clear, victim_addr, victim_line, need_write, output done);
endinterface

`default_nettype wire

/* hdl/lane_steer.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_steer #(
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::WORD_OFF_W
) (
    input  dcache_pkg::word_t     i_req_addr,
    input  dcache_pkg::word_t     i_req_wdata,
    input  dcache_pkg::mem_size_e i_req_size,
    input  logic                  i_req_signed,
    input  dcache_pkg::line_t     i_load_line,
    input  dcache_pkg::line_t     i_fill_line,
    output dcache_pkg::word_t     o_rdata,
    output dcache_pkg::line_t     o_merged_line,
    output dcache_pkg::byte_en_t  o_store_byte_en
);
    import dcache_pkg::*;

    localparam int OFF_W = WORD_OFFSET_WIDTH + 2;

    word_t      load_word;
    word_t      shifted;
    logic [3:0] lane_be;
    line_t      store_bits;

    // word by offset, then the field down to bit 0
    assign load_word = word_t'(i_load_line >> {i_req_addr[OFF_W-1:2], 5'b00000});
    assign shifted   = load_word >> {i_req_addr[1:0], 3'b000};

    always_comb begin
        case (i_req_size)
            SIZE_BYTE: begin
                o_rdata = {{24{i_req_signed & shifted[7]}}, shifted[7:0]};
                lane_be = 4'b0001;
            end
            SIZE_HALF: begin
                o_rdata = {{16{i_req_signed & shifted[15]}}, shifted[15:0]};
                lane_be = 4'b0011;
            end
            default: begin
                o_rdata = shifted;
                lane_be = 4'b1111;
            end
        endcase
    end

    assign o_store_byte_en = byte_en_t'(lane_be) << i_req_addr[OFF_W-1:0];
    assign store_bits      = line_t'(i_req_wdata) << {i_req_addr[OFF_W-1:0], 3'b000};

    always_comb begin
        for (int b = 0; b < LINE_W / 8; b++) begin
            o_merged_line[b*8 +: 8] = o_store_byte_en[b] ? store_bits[b*8 +: 8]
                                                         : i_fill_line[b*8 +: 8];
        end
    end

endmodule

`default_nettype wire

/* hdl/way_store.sv */
`timescale 1ns/100ps
`default_nettype none

module way_store #(
    parameter int INDEX_WIDTH       = dcache_pkg::INDEX_W,
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::WORD_OFF_W
) (
    input  logic      clk,
    input  logic      rstn,
    way_port_if.store way
);
    import dcache_pkg::*;

    localparam int SETS       = 1 << INDEX_WIDTH;
    localparam int LINE_BYTES = 4 << WORD_OFFSET_WIDTH;

    logic [1:0][SETS-1:0]   valid;
    logic [1:0][SETS-1:0]   dirty;
    logic [SETS-1:0]        lru;        // way used last
    logic [INDEX_WIDTH-1:0] idx_q;
    logic [1:0]             valid_q;
    logic [1:0]             hit_vec;
    line_t                  rd_q [2];
    tag_t                   tag_q [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        line_t    data_mem [SETS];
        tag_t     tag_mem [SETS];
        byte_en_t be;

        assign be = way.line_we[w] ? '1 : way.byte_we[w];

        always_ff @(posedge clk) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (be[b]) begin
                    data_mem[way.wr_index][b*8 +: 8] <= way.wr_line[b*8 +: 8];
                end
            end
            if (way.tag_we[w]) begin
                tag_mem[way.wr_index] <= way.tag_in;
            end
            rd_q[w]  <= data_mem[way.rd_index];  // old data on same-cycle write
            tag_q[w] <= tag_mem[way.rd_index];
        end

        assign hit_vec[w] = valid_q[w] && (tag_q[w] == way.tag_in);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid   <= '0;
            dirty   <= '0;
            lru     <= '0;
            idx_q   <= '0;
            valid_q <= '0;
        end else begin
            idx_q   <= way.rd_index;
            valid_q <= {valid[1][way.rd_index], valid[0][way.rd_index]};
            for (int w = 0; w < 2; w++) begin
                if (way.tag_we[w]) begin
                    valid[w][way.wr_index] <= 1'b1;
                end
                if (way.dirty_we[w]) begin
                    dirty[w][way.wr_index] <= way.dirty_val;
                end
            end
            if (way.lru_we) begin
                lru[way.wr_index] <= way.lru_way;
            end
        end
    end

    assign way.rd_line      = {rd_q[1], rd_q[0]};
    assign way.hit          = |hit_vec;
    assign way.hit_way      = hit_vec[1];
    assign way.victim_way   = ~lru[idx_q];    // replace the way not used last
    assign way.victim_dirty = dirty[way.victim_way][idx_q];
    assign way.victim_tag   = tag_q[way.victim_way];
    assign way.victim_line  = rd_q[way.victim_way];

endmodule

`default_nettype wire

/* hdl/writeback_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_unit #(
    parameter int INDEX_WIDTH       = dcache_pkg::INDEX_W,
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::WORD_OFF_W
) (
    input  logic              clk,
    input  logic              rstn,
    wb_port_if.wb             wb,
    output logic              o_mem_wvalid,
    input  logic              i_mem_wready,
    output dcache_pkg::word_t o_mem_waddr,
    output dcache_pkg::line_t o_mem_wdata
);
    import dcache_pkg::*;

    localparam int OFF_W   = WORD_OFFSET_WIDTH + 2;
    localparam int TAG_LSB = INDEX_WIDTH + OFF_W;

    wb_state_e                 state;
    wb_state_e                 state_nxt;
    logic [ADDR_W-TAG_LSB-1:0] tag_q;
    logic [INDEX_WIDTH-1:0]    set_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= WB_INIT;
        end else begin
            state <= state_nxt;
        end
    end

    // victim line buffer, taken before the refill overwrites the way
    always_ff @(posedge clk) begin
        if (wb.start) begin
            tag_q       <= wb.victim_addr[ADDR_W-1:TAG_LSB];
            set_q       <= wb.victim_addr[TAG_LSB-1:OFF_W];
            o_mem_wdata <= wb.victim_line;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WB_INIT:   if (wb.start) state_nxt = wb.need_write ? WB_WRITE : WB_FINISH;
            WB_WRITE:  if (i_mem_wready) state_nxt = WB_FINISH;
            WB_FINISH: if (wb.clear) state_nxt = WB_INIT;
            default:   state_nxt = WB_INIT;
        endcase
    end

    assign o_mem_wvalid = (state == WB_WRITE);
    assign o_mem_waddr  = {tag_q, set_q, {OFF_W{1'b0}}};
    assign wb.done      = (state == WB_FINISH);

endmodule

`default_nettype wire

/* hdl/dcache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl #(
    parameter int INDEX_WIDTH       = dcache_pkg::INDEX_W,
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::WORD_OFF_W
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_rvalid,
    input  logic                  i_wvalid,
    input  dcache_pkg::word_t     i_addr,
    input  dcache_pkg::word_t     i_wdata,
    input  dcache_pkg::mem_size_e i_size,
    input  logic                  i_signed,
    output logic                  o_rready,
    output logic                  o_wready,
    output logic                  o_idle,
    output logic                  o_mem_rvalid,
    input  logic                  i_mem_rready,
    output dcache_pkg::word_t     o_mem_raddr,
    input  dcache_pkg::line_t     i_mem_rdata,
    output dcache_pkg::word_t     o_req_addr,
    output dcache_pkg::word_t     o_req_wdata,
    output dcache_pkg::mem_size_e o_req_size,
    output logic                  o_req_signed,
    output dcache_pkg::line_t     o_load_line,
    input  dcache_pkg::line_t     i_merged_line,
    input  dcache_pkg::byte_en_t  i_store_byte_en,
    way_port_if.ctrl              way,
    wb_port_if.ctrl               wb
);
    import dcache_pkg::*;

    localparam int OFF_W   = WORD_OFFSET_WIDTH + 2;
    localparam int TAG_LSB = INDEX_WIDTH + OFF_W;

    ctrl_state_e            state;
    ctrl_state_e            state_nxt;
    logic                   req_take;
    logic                   req_wr;     // buffered op, 1 = store
    logic                   respond;
    logic [INDEX_WIDTH-1:0] req_index;
    line_t                  ret_buf;

    assign req_take  = (state == IDLE) && (i_rvalid || i_wvalid);
    assign req_index = o_req_addr[TAG_LSB-1:OFF_W];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= IDLE;
            req_wr <= 1'b0;
        end else begin
            state <= state_nxt;
            if (req_take) begin
                req_wr <= i_wvalid;
            end
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (req_take) begin
            o_req_addr   <= i_addr;
            o_req_wdata  <= i_wdata;
            o_req_size   <= i_size;
            o_req_signed <= i_signed;
        end
    end

    // return buffer holds the whole line from one beat
    always_ff @(posedge clk) begin
        if (o_mem_rvalid && i_mem_rready) begin
            ret_buf <= i_mem_rdata;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (req_take) state_nxt = LOOKUP;
            LOOKUP:     state_nxt = way.hit ? IDLE : MISS;
            MISS:       if (i_mem_rready) state_nxt = REFILL;
            REFILL:     state_nxt = WAIT_WRITE;
            WAIT_WRITE: if (wb.done) state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    assign respond = ((state == LOOKUP) && way.hit) || ((state == WAIT_WRITE) && wb.done);
    assign o_rready     = respond && !req_wr;
    assign o_wready     = respond && req_wr;
    assign o_idle       = (state == IDLE);
    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = {o_req_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

    // misses answer from the return buffer
    assign o_load_line = (state == LOOKUP) ? way.rd_line[way.hit_way] : ret_buf;

    // incoming index while idle so the read lands in LOOKUP
    assign way.rd_index = (state == IDLE) ? i_addr[TAG_LSB-1:OFF_W] : req_index;
    assign way.wr_index = req_index;
    assign way.tag_in   = tag_t'(o_req_addr >> TAG_LSB);
    assign way.wr_line  = req_wr ? i_merged_line : ret_buf; // a load refill keeps the memory line

    always_comb begin
        way.line_we    = '0;
        way.byte_we    = '0;
        way.tag_we     = '0;
        way.lru_we     = 1'b0;
        way.lru_way    = way.hit_way;
        way.dirty_we   = '0;
        way.dirty_val  = req_wr; // set only by a store
        wb.start       = 1'b0;
        case (state)
            LOOKUP: begin
                if (way.hit) begin
                    way.lru_we = 1'b1;
                    if (req_wr) begin
                        way.byte_we[way.hit_way]  = i_store_byte_en;
                        way.dirty_we[way.hit_way] = 1'b1;
                    end
                end else begin
                    wb.start = 1'b1;    // victim captured this cycle
                end
            end
            REFILL: begin
                way.line_we[way.victim_way]  = 1'b1;
                way.tag_we[way.victim_way]   = 1'b1;
                way.dirty_we[way.victim_way] = 1'b1;
                way.lru_we                   = 1'b1;
                way.lru_way                  = way.victim_way;
            end
            default: begin
            end
        endcase
    end

    assign wb.clear       = (state == WAIT_WRITE);
    assign wb.need_write  = way.victim_dirty;
    assign wb.victim_line = way.victim_line;
    assign wb.victim_addr = (word_t'(way.victim_tag) << TAG_LSB) | (word_t'(req_index) << OFF_W);

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_WIDTH       = dcache_pkg::INDEX_W,
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::WORD_OFF_W
) (
    input  logic                  clk,
    input  logic                  rstn,
    // pipeline side
    input  logic                  i_rvalid,
    input  logic                  i_wvalid,
    input  dcache_pkg::word_t     i_addr,
    input  dcache_pkg::word_t     i_wdata,
    input  dcache_pkg::mem_size_e i_size,
    input  logic                  i_signed,
    output logic                  o_rready,
    output logic                  o_wready,
    output dcache_pkg::word_t     o_rdata,
    output logic                  o_idle,
    // memory read channel
    output logic                  o_mem_rvalid,
    input  logic                  i_mem_rready,
    output dcache_pkg::word_t     o_mem_raddr,
    input  dcache_pkg::line_t     i_mem_rdata,
    // memory write channel
    output logic                  o_mem_wvalid,
    input  logic                  i_mem_wready,
    output dcache_pkg::word_t     o_mem_waddr,
    output dcache_pkg::line_t     o_mem_wdata
);
    dcache_pkg::word_t     req_addr;
    dcache_pkg::word_t     req_wdata;
    dcache_pkg::mem_size_e req_size;
    logic                  req_signed;
    dcache_pkg::line_t     load_line;
    dcache_pkg::line_t     merged_line;
    dcache_pkg::byte_en_t  store_byte_en;

    way_port_if #(.INDEX_WIDTH(INDEX_WIDTH)) u_way_port ();
    wb_port_if u_wb_port ();

    dcache_ctrl #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_ctrl (
        .clk             (clk),
        .rstn            (rstn),
        .i_rvalid        (i_rvalid),
        .i_wvalid        (i_wvalid),
        .i_addr          (i_addr),
        .i_wdata         (i_wdata),
        .i_size          (i_size),
        .i_signed        (i_signed),
        .o_rready        (o_rready),
        .o_wready        (o_wready),
        .o_idle          (o_idle),
        .o_mem_rvalid    (o_mem_rvalid),
        .i_mem_rready    (i_mem_rready),
        .o_mem_raddr     (o_mem_raddr),
        .i_mem_rdata     (i_mem_rdata),
        .o_req_addr      (req_addr),
        .o_req_wdata     (req_wdata),
        .o_req_size      (req_size),
        .o_req_signed    (req_signed),
        .o_load_line     (load_line),
        .i_merged_line   (merged_line),
        .i_store_byte_en (store_byte_en),
        .way             (u_way_port.ctrl),
        .wb              (u_wb_port.ctrl)
    );

    way_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_way_store (
        .clk  (clk),
        .rstn (rstn),
        .way  (u_way_port.store)
    );

    writeback_unit #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_writeback (
        .clk          (clk),
        .rstn         (rstn),
        .wb           (u_wb_port.wb),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_wready (i_mem_wready),
        .o_mem_waddr  (o_mem_waddr),
        .o_mem_wdata  (o_mem_wdata)
    );

    // load_line is the refilled line outside LOOKUP, so it also feeds the merge
    lane_steer #(
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_lane_steer (
        .i_req_addr      (req_addr),
        .i_req_wdata     (req_wdata),
        .i_req_size      (req_size),
        .i_req_signed    (req_signed),
        .i_load_line     (load_line),
        .i_fill_line     (load_line),
        .o_rdata         (o_rdata),
        .o_merged_line   (merged_line),
        .o_store_byte_en (store_byte_en)
    );

endmodule

`default_nettype wire

/* dv/tb_dcache.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MAX_TESTS = 64;
    localparam int SETS = 1 << INDEX_W;
    localparam int OFF_W = WORD_OFF_W + 2;
    localparam int TAG_LSB = INDEX_W + OFF_W;

    logic      clk;
    logic      rstn;
    logic      i_rvalid;
    logic      i_wvalid;
    word_t     i_addr;
    word_t     i_wdata;
    mem_size_e i_size;
    logic      i_signed;
    logic      o_rready;
    logic      o_wready;
    word_t     o_rdata;
    logic      o_idle;
    logic      o_mem_rvalid;
    logic      i_mem_rready;
    word_t     o_mem_raddr;
    line_t     i_mem_rdata;
    logic      o_mem_wvalid;
    logic      i_mem_wready;
    word_t     o_mem_waddr;
    line_t     o_mem_wdata;

    // test table loaded from the data file
    string     t_name [MAX_TESTS];
    logic      t_store [MAX_TESTS];
    mem_size_e t_size [MAX_TESTS];
    logic      t_signed [MAX_TESTS];
    word_t     t_addr [MAX_TESTS];
    word_t     t_wdata [MAX_TESTS];
    word_t     t_exp [MAX_TESTS];
    int        n_tests;

    // tag model of the cache
    tag_t      ref_tag [2][SETS];
    logic      ref_valid [2][SETS];
    logic      ref_dirty [2][SETS];
    logic      ref_lru [SETS];      // way used last

    line_t     mem_lines [word_t];  // lines written back by the DUT
    word_t     shadow [word_t];     // every stored word
    integer    seed = 80936;
    int        rd_delay;
    int        wr_delay;
    int        rd_count;
    int        wr_count;
    word_t     exp_rd_addr;
    word_t     exp_wb_addr;
    string     cur_name;
    int        mismatches;
    int        other_errors;
    int        cycles;
    int        cycle_limit;

    dcache_top i_dcache_top (
        .clk          (clk),
        .rstn         (rstn),
        .i_rvalid     (i_rvalid),
        .i_wvalid     (i_wvalid),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_size       (i_size),
        .i_signed     (i_signed),
        .o_rready     (o_rready),
        .o_wready     (o_wready),
        .o_rdata      (o_rdata),
        .o_idle       (o_idle),
        .o_mem_rvalid (o_mem_rvalid),
        .i_mem_rready (i_mem_rready),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_wready (i_mem_wready),
        .o_mem_waddr  (o_mem_waddr),
        .o_mem_wdata  (o_mem_wdata)
    );

    always #10 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %0s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %0s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            mismatches++;
            $display("mismatch %0s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic word_t shadow_word(input word_t addr);
        if (shadow.exists(addr)) return shadow[addr];
        return addr + 32'h1000_0000;  // memory rule
    endfunction

    function automatic line_t shadow_line(input word_t base);
        line_t l;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*32 +: 32] = shadow_word(base + 4 * w);
        end
        return l;
    endfunction

    function automatic line_t read_mem_line(input word_t base);
        line_t l;
        if (mem_lines.exists(base)) return mem_lines[base];
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            l[w*32 +: 32] = base + 4 * w + 32'h1000_0000;
        end
        return l;
    endfunction

    function automatic void update_shadow(input word_t addr, input word_t data,
                                          input mem_size_e size);
        word_t wa;
        word_t w;
        wa = {addr[ADDR_W-1:2], 2'b00};
        w = shadow_word(wa);
        case (size)
            SIZE_BYTE: w[addr[1:0]*8 +: 8] = data[7:0];
            SIZE_HALF: w[addr[1]*16 +: 16] = data[15:0];
            default:   w = data;
        endcase
        shadow[wa] = w;
    endfunction

    function automatic int next_delay();
        return $unsigned($random(seed)) % 5;
    endfunction

    // predicts hit and write-back and updates the tag model
    task automatic predict_access(input word_t addr, input logic is_store, output logic hit,
                                  output int n_wb, output word_t wb_addr);
        int   idx;
        int   v;
        tag_t tag;
        idx = addr[TAG_LSB-1:OFF_W];
        tag = addr[ADDR_W-1:TAG_LSB];
        hit = 1'b0;
        n_wb = 0;
        wb_addr = '0;
        v = 0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                hit = 1'b1;
                v = w;
            end
        end
        if (!hit) begin
            v = ref_lru[idx] ? 0 : 1;
            if (ref_valid[v][idx] && ref_dirty[v][idx]) begin
                n_wb = 1;
                wb_addr = {ref_tag[v][idx], idx[INDEX_W-1:0], {OFF_W{1'b0}}};
            end
            ref_tag[v][idx] = tag;
            ref_valid[v][idx] = 1'b1;
            ref_dirty[v][idx] = 1'b0;
        end
        if (is_store) ref_dirty[v][idx] = 1'b1;
        ref_lru[idx] = v;
    endtask

    task automatic load_tests();
        int              fd;
        int              code;
        int              sgn;
        logic [8*24-1:0] name_buf;
        logic [8*8-1:0]  op_buf;
        logic [8*8-1:0]  size_buf;
        logic [8*160-1:0] skip_buf;
        word_t           addr_v;
        word_t           wdata_v;
        word_t           exp_v;
        n_tests = 0;
        fd = $fopen("dv/dcache_testdata.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("error: cannot open dv/dcache_testdata.txt");
        end else begin
            while ($fscanf(fd, "%s", name_buf) == 1) begin
                if (name_buf == "#") begin
                    code = $fgets(skip_buf, fd);  // column description
                end else begin
                    code = $fscanf(fd, "%s %s %d %h %h %h", op_buf, size_buf, sgn,
                                   addr_v, wdata_v, exp_v);
                    if (code != 6 || n_tests >= MAX_TESTS) begin
                        other_errors++;
                        $display("error: data line after entry %0d cannot be read", n_tests);
                    end else begin
                        t_name[n_tests] = string'(name_buf);
                        t_store[n_tests] = (op_buf == "st");
                        if (size_buf == "b") t_size[n_tests] = SIZE_BYTE;
                        else if (size_buf == "h") t_size[n_tests] = SIZE_HALF;
                        else t_size[n_tests] = SIZE_WORD;
                        t_signed[n_tests] = (sgn != 0);
                        t_addr[n_tests] = addr_v;
                        t_wdata[n_tests] = wdata_v;
                        t_exp[n_tests] = exp_v;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_tests == 0) begin
            other_errors++;
            $display("error: the data file holds no accesses");
        end
    endtask

    task automatic run_access(input int i);
        logic  exp_hit;
        int    exp_wb;
        int    wait_cyc;
        word_t wb_addr;
        cur_name = t_name[i];
        predict_access(t_addr[i], t_store[i], exp_hit, exp_wb, wb_addr);
        exp_wb_addr = wb_addr;
        exp_rd_addr = {t_addr[i][ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        rd_count = 0;
        wr_count = 0;
        if (t_store[i]) update_shadow(t_addr[i], t_wdata[i], t_size[i]);
        @(negedge clk);
        while (!o_idle) @(negedge clk);
        @(posedge clk);
        i_rvalid <= !t_store[i];
        i_wvalid <= t_store[i];
        i_addr   <= t_addr[i];
        i_wdata  <= t_wdata[i];
        i_size   <= t_size[i];
        i_signed <= t_signed[i];
        @(posedge clk);               // request taken here
        i_rvalid <= 1'b0;
        i_wvalid <= 1'b0;
        wait_cyc = 0;
        @(negedge clk);
        while (!(o_rready || o_wready) && wait_cyc < CYCLES_PER_TEST) begin
            wait_cyc++;
            @(negedge clk);
        end
        if (!(o_rready || o_wready)) begin
            other_errors++;
            $display("error %0s: no response within %0d cycles", cur_name, CYCLES_PER_TEST);
        end else begin
            if (o_wready != t_store[i]) begin
                other_errors++;
                $display("error %0s: answered with the wrong ready strobe", cur_name);
            end
            if (exp_hit) check_count({cur_name, " hit latency"}, 0, wait_cyc);
            if (!t_store[i]) check_word(cur_name, t_exp[i], o_rdata);
            check_count({cur_name, " memory reads"}, exp_hit ? 0 : 1, rd_count);
            check_count({cur_name, " memory writes"}, exp_wb, wr_count);
        end
    endtask

    // memory model with random ready delays on both channels
    always @(posedge clk) begin
        if (!rstn) begin
            i_mem_rready <= 1'b0;
            i_mem_wready <= 1'b0;
            rd_delay = next_delay();
            wr_delay = next_delay();
        end else begin
            if (i_mem_rready) begin
                i_mem_rready <= 1'b0;
            end else if (o_mem_rvalid) begin
                if (rd_delay == 0) begin
                    i_mem_rready <= 1'b1;
                    i_mem_rdata  <= read_mem_line(o_mem_raddr);
                    rd_count++;
                    check_word({cur_name, " read address"}, exp_rd_addr, o_mem_raddr);
                    rd_delay = next_delay();
                end else begin
                    rd_delay--;
                end
            end
            if (i_mem_wready) begin
                i_mem_wready <= 1'b0;
            end else if (o_mem_wvalid) begin
                if (wr_delay == 0) begin
                    i_mem_wready <= 1'b1;
                    wr_count++;
                    check_word({cur_name, " write address"}, exp_wb_addr, o_mem_waddr);
                    check_line({cur_name, " write data"}, shadow_line(o_mem_waddr),
                               o_mem_wdata);
                    mem_lines[o_mem_waddr] = o_mem_wdata;
                    wr_delay = next_delay();
                end else begin
                    wr_delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("error: run stopped after %0d cycles without finishing", cycles);
            $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin : main
        clk = 1'b0;
        rstn = 1'b0;
        i_rvalid = 1'b0;
        i_wvalid = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        i_size = SIZE_WORD;
        i_signed = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_wready = 1'b0;
        i_mem_rdata = '0;
        mismatches = 0;
        other_errors = 0;
        cycles = 0;
        rd_count = 0;
        wr_count = 0;
        exp_rd_addr = '0;
        exp_wb_addr = '0;
        cur_name = "reset";
        for (int s = 0; s < SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
        cycle_limit = RESET_CYCLES + 20;
        load_tests();
        cycle_limit = RESET_CYCLES + 20 + CYCLES_PER_TEST * n_tests;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (!o_idle || o_rready || o_wready || o_mem_rvalid || o_mem_wvalid) begin
            other_errors++;
            $display("error: outputs not in their reset state after reset");
        end
        for (int i = 0; i < n_tests; i++) begin
            run_access(i);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/dcache_pkg.sv
hdl/dcache_ifs.sv
hdl/lane_steer.sv
hdl/way_store.sv
hdl/writeback_unit.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/tb_dcache.sv

/* dv/dcache_testdata.txt */
# name op(ld/st) size(b/h/w) signed address(hex) write_data(hex) expected_load(hex)
# memory word at byte address A starts as A + 10000000, stores list 00000000 as expected
rd_miss   ld w 0 00000100 00000000 10000100
rd_hit    ld w 0 00000104 00000000 10000104
lb_s0     ld b 1 800080f0 00000000 fffffff0
lbu_0     ld b 0 800080f0 00000000 000000f0
lb_s1     ld b 1 800080f1 00000000 ffffff80
lb_s2     ld b 1 800080f2 00000000 00000000
lbu_3     ld b 0 800080f3 00000000 00000090
lb_s3     ld b 1 800080f3 00000000 ffffff90
lh_s0     ld h 1 800080f0 00000000 ffff80f0
lhu_0     ld h 0 800080f0 00000000 000080f0
lh_s2     ld h 1 800080f2 00000000 ffff9000
lhu_2     ld h 0 800080f2 00000000 00009000
sb_hit    st b 0 00000109 000000ab 00000000
ld_sb     ld w 0 00000108 00000000 1000ab08
sh_hit    st h 0 0000010e 0000cdef 00000000
ld_sh     ld w 0 0000010c 00000000 cdef010c
sw_hit    st w 0 00000100 deadbeef 00000000
ld_sw     ld w 0 00000100 00000000 deadbeef
st_miss   st w 0 00000214 12345678 00000000
ld_stm    ld w 0 00000214 00000000 12345678
ld_stm2   ld w 0 00000218 00000000 10000218
ld_lru2   ld w 0 00001104 00000000 10001104
ld_lru3   ld w 0 00002108 00000000 10002108
ld_back   ld w 0 00000108 00000000 1000ab08
ld_set1a  ld w 0 00001210 00000000 10001210
ld_set1b  ld w 0 00002210 00000000 10002210
ld_stm3   ld w 0 00000214 00000000 12345678
